//--- rtl/blimp_pkg.sv
// ----------------------------------------
// Shared widths, types and message structs
// Opcode constants and multiplier FSM enum
// ----------------------------------------
package blimp_pkg;

  // ----------------------------------------
  // Widths and sizes
  // ----------------------------------------
  localparam int XLEN_W     = 32;
  localparam int OPAQ_W     = 8;
  localparam int NUM_REGS   = 32;
  localparam int REG_IDX_W  = $clog2(NUM_REGS);
  localparam int MUL_CYCLES = 32;

  // Plain vector types
  typedef logic [XLEN_W-1:0]             word_t;
  typedef logic [REG_IDX_W-1:0]          reg_idx_t;
  typedef logic [OPAQ_W-1:0]             opaq_t;
  typedef logic [$clog2(MUL_CYCLES)-1:0] mul_cnt_t;

  // First fetch address and fetch stride
  localparam word_t RESET_PC   = 32'h0000_0000;
  localparam word_t INST_BYTES = 32'd4;

  // ----------------------------------------
  // Encodings
  // ----------------------------------------
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [2:0] F3_ADD     = 3'b000;
  localparam logic [6:0] F7_ADD     = 7'b0000000;
  localparam logic [6:0] F7_MUL     = 7'b0000001;

  // ----------------------------------------
  // Messages
  // ----------------------------------------
  // Fetch request, tag travels back in the response
  typedef struct packed {
    opaq_t opaque;
    word_t addr;
  } mem_req_t;

  typedef struct packed {
    opaq_t opaque;
    word_t data;
  } mem_resp_t;

  // One retired instruction
  typedef struct packed {
    word_t    pc;
    reg_idx_t waddr;
    word_t    wdata;
    logic     wen;
  } inst_trace_t;

  // Decoded instruction with its operands
  typedef struct packed {
    word_t    pc;
    reg_idx_t waddr;
    logic     wen;
    word_t    op_a;
    word_t    op_b;
    logic     is_mul;
  } issue_t;

  // Multiplier FSM
  typedef enum logic [1:0] {
    MUL_IDLE = 2'd0,
    MUL_BUSY = 2'd1,
    MUL_DONE = 2'd2
  } mul_state_e;

endpackage

//--- rtl/blimp_fetch.sv
`timescale 1ns/100ps
// ----------------------------------------
// Fetch unit with tagged memory requests
// Two-slot buffer restores program order
// ----------------------------------------
module blimp_fetch (
  input  logic                 clk,
  input  logic                 rst_n,
  // Instruction memory request
  output logic                 mem_req_val,
  input  logic                 mem_req_rdy,
  output blimp_pkg::mem_req_t  mem_req,
  // Instruction memory response
  input  logic                 mem_resp_val,
  output logic                 mem_resp_rdy,
  input  blimp_pkg::mem_resp_t mem_resp,
  // To decode
  output logic                 inst_val,
  input  logic                 inst_rdy,
  output blimp_pkg::word_t     inst_pc,
  output blimp_pkg::word_t     inst_word
);

  // Low through reset, high from the first cycle after it
  logic             fetch_en;
  blimp_pkg::word_t next_pc;
  blimp_pkg::opaq_t next_tag;
  // Slot allocated at request, filled at response
  logic [1:0]       slot_busy;
  logic [1:0]       slot_full;
  logic             head;
  blimp_pkg::word_t slot_pc   [2];
  blimp_pkg::word_t slot_data [2];
  logic             req_slot;
  logic             resp_slot;
  logic             req_fire;
  logic             resp_fire;
  logic             inst_fire;

  // Tag bit 0 picks the slot
  assign req_slot  = next_tag[0];
  assign resp_slot = mem_resp.opaque[0];

  // Slot for next tag frees only in order, so valid holds once raised
  assign mem_req_val    = fetch_en && !slot_busy[req_slot];
  assign mem_req.opaque = next_tag;
  assign mem_req.addr   = next_pc;

  // Every outstanding tag owns a slot
  assign mem_resp_rdy = fetch_en;

  // Oldest slot goes to decode
  assign inst_val  = slot_full[head];
  assign inst_pc   = slot_pc[head];
  assign inst_word = slot_data[head];

  assign req_fire  = mem_req_val && mem_req_rdy;
  assign resp_fire = mem_resp_val && mem_resp_rdy;
  assign inst_fire = inst_val && inst_rdy;

  // ----------------------------------------
  // Control state
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fetch_en  <= 1'b0;
      next_pc   <= blimp_pkg::RESET_PC;
      next_tag  <= '0;
      slot_busy <= '0;
      slot_full <= '0;
      head      <= 1'b0;
    end else begin
      fetch_en <= 1'b1;
      if (req_fire) begin
        next_pc  <= next_pc + blimp_pkg::INST_BYTES;
        next_tag <= next_tag + 1'b1;
      end
      // Head slot released on delivery
      if (inst_fire) begin
        slot_busy[head] <= 1'b0;
        slot_full[head] <= 1'b0;
        head            <= ~head;
      end
      // Never the head slot when both fire
      if (req_fire) begin
        slot_busy[req_slot] <= 1'b1;
      end
      if (resp_fire) begin
        slot_full[resp_slot] <= 1'b1;
      end
    end
  end

  // Slot payload
  always_ff @(posedge clk) begin
    if (req_fire) begin
      slot_pc[req_slot] <= next_pc;
    end
    if (resp_fire) begin
      slot_data[resp_slot] <= mem_resp.data;
    end
  end

endmodule

//--- rtl/blimp_regfile.sv
`timescale 1ns/100ps
// ----------------------------------------
// Register file, 2 read and 1 write port
// x0 reads zero, writes bypass to reads
// ----------------------------------------
module blimp_regfile (
  input  logic                clk,
  input  logic                rst_n,
  input  blimp_pkg::reg_idx_t raddr0,
  output blimp_pkg::word_t    rdata0,
  input  blimp_pkg::reg_idx_t raddr1,
  output blimp_pkg::word_t    rdata1,
  input  logic                wen,
  input  blimp_pkg::reg_idx_t waddr,
  input  blimp_pkg::word_t    wdata
);

  blimp_pkg::word_t regs [blimp_pkg::NUM_REGS];
  logic             wr_live;

  // x0 writes dropped
  assign wr_live = wen && (waddr != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < blimp_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[waddr] <= wdata;
    end
  end

  // Same-cycle write wins over the stored value
  function automatic blimp_pkg::word_t read_port(input blimp_pkg::reg_idx_t raddr);
    if (wr_live && (raddr == waddr)) begin
      return wdata;
    end
    return regs[raddr];
  endfunction

  assign rdata0 = read_port(raddr0);
  assign rdata1 = read_port(raddr1);

endmodule

//--- rtl/blimp_decode_issue.sv
`timescale 1ns/100ps
// ----------------------------------------
// Decode and issue for addi, add and mul
// Stalls while the multiplier is working
// ----------------------------------------
module blimp_decode_issue (
  input  logic                clk,
  input  logic                rst_n,
  // From fetch
  input  logic                inst_val,
  output logic                inst_rdy,
  input  blimp_pkg::word_t    inst_pc,
  input  blimp_pkg::word_t    inst_word,
  // Register file reads
  output blimp_pkg::reg_idx_t raddr0,
  output blimp_pkg::reg_idx_t raddr1,
  input  blimp_pkg::word_t    rdata0,
  input  blimp_pkg::word_t    rdata1,
  // Dispatch
  input  logic                mul_busy,
  output logic                issue_val,
  output logic                mul_start,
  output blimp_pkg::issue_t   issue
);

  // Instruction fields
  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  blimp_pkg::reg_idx_t rd;
  blimp_pkg::reg_idx_t rs1;
  blimp_pkg::reg_idx_t rs2;
  blimp_pkg::word_t    imm_i;
  // Classification
  logic                is_add;
  logic                is_addi;
  logic                is_mul;
  logic                fire;
  // Multiplier was busy last cycle
  logic                mul_busy_q;

  // ----------------------------------------
  // Field split
  // ----------------------------------------
  assign opcode = inst_word[6:0];
  assign rd     = inst_word[11:7];
  assign funct3 = inst_word[14:12];
  assign rs1    = inst_word[19:15];
  assign rs2    = inst_word[24:20];
  assign funct7 = inst_word[31:25];

  // I-type immediate, sign extended
  assign imm_i = {{20{inst_word[31]}}, inst_word[31:20]};

  assign is_add  = (opcode == blimp_pkg::OPC_OP) && (funct3 == blimp_pkg::F3_ADD)
                   && (funct7 == blimp_pkg::F7_ADD);
  assign is_mul  = (opcode == blimp_pkg::OPC_OP) && (funct3 == blimp_pkg::F3_ADD)
                   && (funct7 == blimp_pkg::F7_MUL);
  assign is_addi = (opcode == blimp_pkg::OPC_OP_IMM) && (funct3 == blimp_pkg::F3_ADD);

  // Operand reads
  assign raddr0 = rs1;
  assign raddr1 = rs2;

  // ----------------------------------------
  // Issue message
  // ----------------------------------------
  // Unknown words retire with wen low
  assign issue.pc     = inst_pc;
  assign issue.waddr  = rd;
  assign issue.wen    = is_add || is_addi || is_mul;
  assign issue.op_a   = rdata0;
  assign issue.op_b   = is_addi ? imm_i : rdata1;
  assign issue.is_mul = is_mul;

  // Multiplier result retires the cycle after busy drops,
  // so hold off one more cycle to keep writeback single source
  assign inst_rdy = !mul_busy && !mul_busy_q;
  assign fire     = inst_val && inst_rdy;

  // One-cycle pulses, adder path or multiplier
  assign issue_val = fire && !issue.is_mul;
  assign mul_start = fire && issue.is_mul;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mul_busy_q <= 1'b0;
    end else begin
      mul_busy_q <= mul_busy;
    end
  end

endmodule

//--- rtl/blimp_mul_unit.sv
`timescale 1ns/100ps
// ----------------------------------------
// Iterative shift-add multiplier, low word
// ----------------------------------------
module blimp_mul_unit (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              mul_start,
  input  blimp_pkg::issue_t issue,
  output logic              mul_busy,
  output logic              mul_done,
  output blimp_pkg::word_t  mul_result,
  output blimp_pkg::issue_t mul_issue
);

  blimp_pkg::mul_state_e state;
  blimp_pkg::mul_cnt_t   cnt;
  // Datapath registers
  blimp_pkg::word_t      mcand;
  blimp_pkg::word_t      mplier;
  blimp_pkg::word_t      acc;
  blimp_pkg::issue_t     held;
  logic                  load;

  assign load = (state == blimp_pkg::MUL_IDLE) && mul_start;

  // ----------------------------------------
  // FSM
  // ----------------------------------------
  // Load cycle does step 0, BUSY does the remaining MUL_CYCLES-1
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= blimp_pkg::MUL_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        blimp_pkg::MUL_IDLE: begin
          if (mul_start) begin
            state <= blimp_pkg::MUL_BUSY;
            cnt   <= blimp_pkg::mul_cnt_t'(1);
          end
        end
        blimp_pkg::MUL_BUSY: begin
          cnt <= cnt + 1'b1;
          if (cnt == blimp_pkg::mul_cnt_t'(blimp_pkg::MUL_CYCLES - 1)) begin
            state <= blimp_pkg::MUL_DONE;
          end
        end
        blimp_pkg::MUL_DONE: begin
          state <= blimp_pkg::MUL_IDLE;
        end
        default: begin
          state <= blimp_pkg::MUL_IDLE;
        end
      endcase
    end
  end

  // ----------------------------------------
  // Shift-add datapath
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (load) begin
      // Bit 0 of op_b handled here
      acc    <= issue.op_b[0] ? issue.op_a : '0;
      mcand  <= issue.op_a << 1;
      mplier <= issue.op_b >> 1;
      held   <= issue;
    end else if (state == blimp_pkg::MUL_BUSY) begin
      acc    <= acc + (mplier[0] ? mcand : '0);
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // Upper product bits shift out and are dropped
  assign mul_busy   = (state == blimp_pkg::MUL_BUSY);
  assign mul_done   = (state == blimp_pkg::MUL_DONE);
  assign mul_result = acc;
  assign mul_issue  = held;

endmodule

//--- rtl/blimp_writeback.sv
`timescale 1ns/100ps
// ----------------------------------------
// Writeback and instruction trace output
// ----------------------------------------
module blimp_writeback (
  input  logic                   clk,
  input  logic                   rst_n,
  // Adder path
  input  logic                   issue_val,
  input  blimp_pkg::issue_t      issue,
  // Multiplier path
  input  logic                   mul_done,
  input  blimp_pkg::issue_t      mul_issue,
  input  blimp_pkg::word_t       mul_result,
  // Register file write
  output logic                   rf_wen,
  output blimp_pkg::reg_idx_t    rf_waddr,
  output blimp_pkg::word_t       rf_wdata,
  // Trace
  output logic                   trace_val,
  output blimp_pkg::inst_trace_t trace
);

  logic              res_val;
  blimp_pkg::issue_t res_issue;
  blimp_pkg::word_t  res_data;

  // Decode stall keeps the two sources apart
  assign res_val   = issue_val || mul_done;
  assign res_issue = mul_done ? mul_issue : issue;
  assign res_data  = mul_done ? mul_result : (issue.op_a + issue.op_b);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      trace_val <= 1'b0;
    end else begin
      trace_val <= res_val;
    end
  end

  // Trace keeps the computed value and wen, even for x0
  always_ff @(posedge clk) begin
    if (res_val) begin
      trace.pc    <= res_issue.pc;
      trace.waddr <= res_issue.waddr;
      trace.wdata <= res_data;
      trace.wen   <= res_issue.wen;
    end
  end

  // Register write follows the registered trace
  // Regfile bypass serves the instruction issuing now
  // No write to x0
  assign rf_wen   = trace_val && trace.wen && (trace.waddr != '0);
  assign rf_waddr = trace.waddr;
  assign rf_wdata = trace.wdata;

endmodule

//--- rtl/blimp_v1.sv
`timescale 1ns/100ps
// ----------------------------------------
// Core top, fetch through writeback
// ----------------------------------------
module blimp_v1 (
  input  logic                   clk,
  input  logic                   rst_n,
  // Instruction memory
  output logic                   mem_req_val,
  input  logic                   mem_req_rdy,
  output blimp_pkg::mem_req_t    mem_req,
  input  logic                   mem_resp_val,
  output logic                   mem_resp_rdy,
  input  blimp_pkg::mem_resp_t   mem_resp,
  // Retire trace
  output logic                   trace_val,
  output blimp_pkg::inst_trace_t trace
);

  // Fetch to decode
  logic                inst_val;
  logic                inst_rdy;
  blimp_pkg::word_t    inst_pc;
  blimp_pkg::word_t    inst_word;
  // Register file
  blimp_pkg::reg_idx_t raddr0;
  blimp_pkg::reg_idx_t raddr1;
  blimp_pkg::word_t    rdata0;
  blimp_pkg::word_t    rdata1;
  logic                rf_wen;
  blimp_pkg::reg_idx_t rf_waddr;
  blimp_pkg::word_t    rf_wdata;
  // Issue and multiplier
  logic                issue_val;
  logic                mul_start;
  blimp_pkg::issue_t   issue;
  logic                mul_busy;
  logic                mul_done;
  blimp_pkg::word_t    mul_result;
  blimp_pkg::issue_t   mul_issue;

  blimp_fetch u_fetch (
    .clk          (clk),
    .rst_n        (rst_n),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_req      (mem_req),
    .mem_resp_val (mem_resp_val),
    .mem_resp_rdy (mem_resp_rdy),
    .mem_resp     (mem_resp),
    .inst_val     (inst_val),
    .inst_rdy     (inst_rdy),
    .inst_pc      (inst_pc),
    .inst_word    (inst_word)
  );

  blimp_decode_issue u_decode_issue (
    .clk       (clk),
    .rst_n     (rst_n),
    .inst_val  (inst_val),
    .inst_rdy  (inst_rdy),
    .inst_pc   (inst_pc),
    .inst_word (inst_word),
    .raddr0    (raddr0),
    .raddr1    (raddr1),
    .rdata0    (rdata0),
    .rdata1    (rdata1),
    .mul_busy  (mul_busy),
    .issue_val (issue_val),
    .mul_start (mul_start),
    .issue     (issue)
  );

  blimp_regfile u_regfile (
    .clk    (clk),
    .rst_n  (rst_n),
    .raddr0 (raddr0),
    .rdata0 (rdata0),
    .raddr1 (raddr1),
    .rdata1 (rdata1),
    .wen    (rf_wen),
    .waddr  (rf_waddr),
    .wdata  (rf_wdata)
  );

  blimp_mul_unit u_mul_unit (
    .clk        (clk),
    .rst_n      (rst_n),
    .mul_start  (mul_start),
    .issue      (issue),
    .mul_busy   (mul_busy),
    .mul_done   (mul_done),
    .mul_result (mul_result),
    .mul_issue  (mul_issue)
  );

  blimp_writeback u_writeback (
    .clk        (clk),
    .rst_n      (rst_n),
    .issue_val  (issue_val),
    .issue      (issue),
    .mul_done   (mul_done),
    .mul_issue  (mul_issue),
    .mul_result (mul_result),
    .rf_wen     (rf_wen),
    .rf_waddr   (rf_waddr),
    .rf_wdata   (rf_wdata),
    .trace_val  (trace_val),
    .trace      (trace)
  );

endmodule

//--- sim/blimp_trace_checker.sv
`timescale 1ns/100ps
// ----------------------------------------
// Trace checker for the blimp_v1 core
// First request, retire order and values
// ----------------------------------------
module blimp_trace_checker (
  input  logic                   clk,
  input  logic                   rst_n,
  // Memory channel, watched only
  input  logic                   mem_req_val,
  input  blimp_pkg::mem_req_t    mem_req,
  input  logic                   mem_resp_val,
  input  logic                   mem_resp_rdy,
  // Retire trace
  input  logic                   trace_val,
  input  blimp_pkg::inst_trace_t trace,
  // Expected row for row_idx
  input  int                     num_rows,
  input  blimp_pkg::inst_trace_t exp_trace,
  output int                     row_idx,
  output int                     err_count,
  output logic                   done,
  output logic                   stalled
);

  // Longest gap between retires, mul plus memory delay fits easily
  localparam int STALL_LIMIT = 300;

  logic seen_req;
  logic seen_resp;
  int   idle;
  int   row_errs;

  task automatic compare_field(input string            name,
                               input blimp_pkg::word_t exp_val,
                               input blimp_pkg::word_t act_val);
    if (exp_val !== act_val) begin
      $display("FAIL %0t %s expected %h actual %h", $time, name, exp_val, act_val);
      err_count++;
      row_errs++;
    end
  endtask

  // waddr and wdata are don't care for unknown words
  task automatic check_row();
    row_errs = 0;
    compare_field("trace.pc", exp_trace.pc, trace.pc);
    compare_field("trace.wen", blimp_pkg::word_t'(exp_trace.wen),
                  blimp_pkg::word_t'(trace.wen));
    if (exp_trace.wen) begin
      compare_field("trace.waddr", blimp_pkg::word_t'(exp_trace.waddr),
                    blimp_pkg::word_t'(trace.waddr));
      compare_field("trace.wdata", exp_trace.wdata, trace.wdata);
    end
    if (row_errs == 0) begin
      $display("PASS row %0d pc %h waddr %0d wdata %h wen %0b", row_idx, trace.pc,
               trace.waddr, trace.wdata, trace.wen);
    end
    row_idx++;
    if (row_idx == num_rows) begin
      done = 1'b1;
    end
  endtask

  // ----------------------------------------
  // Sampled mid-cycle, all signals settled
  // ----------------------------------------
  always @(negedge clk) begin
    if (!rst_n) begin
      seen_req  = 1'b0;
      seen_resp = 1'b0;
      idle      = 0;
      row_idx   = 0;
      err_count = 0;
      done      = 1'b0;
      stalled   = 1'b0;
    end else begin
      // First fetch goes to RESET_PC with tag 0
      if (mem_req_val && !seen_req) begin
        row_errs = 0;
        compare_field("mem_req.addr", 32'h0, mem_req.addr);
        compare_field("mem_req.opaque", 32'h0, blimp_pkg::word_t'(mem_req.opaque));
        if (row_errs == 0) begin
          $display("PASS first request addr %h tag %0d", mem_req.addr, mem_req.opaque);
        end
        seen_req = 1'b1;
      end
      if (trace_val && !seen_resp) begin
        $display("trace_val went high at %0t before any memory response", $time);
        err_count++;
      end
      // Every outstanding tag has a slot
      if (mem_resp_val && !mem_resp_rdy) begin
        $display("mem_resp_rdy was low at %0t while a response was offered", $time);
        err_count++;
      end
      if (mem_resp_val && mem_resp_rdy) begin
        seen_resp = 1'b1;
      end
      if (trace_val && !done) begin
        check_row();
      end
      // Watchdog on retires
      if (trace_val || done) begin
        idle = 0;
      end else begin
        idle++;
      end
      if ((idle > STALL_LIMIT) && !stalled) begin
        $display("No instruction retired for %0d cycles, stuck before row %0d",
                 STALL_LIMIT, row_idx);
        stalled = 1'b1;
      end
    end
  end

endmodule

//--- sim/blimp_v1_tb.sv
`timescale 1ns/100ps
// ----------------------------------------
// Testbench top for the blimp_v1 core
// Program table, tagged memory model, DUT
// ----------------------------------------
module blimp_v1_tb;

  localparam int MAX_ROWS  = 64;
  localparam int RUN_LIMIT = 5000;

  logic                   clk;
  logic                   rst_n;
  // DUT ports
  logic                   mem_req_val;
  logic                   mem_req_rdy;
  blimp_pkg::mem_req_t    mem_req;
  logic                   mem_resp_val;
  logic                   mem_resp_rdy;
  blimp_pkg::mem_resp_t   mem_resp;
  logic                   trace_val;
  blimp_pkg::inst_trace_t trace;

  // Program words and expected retire records
  blimp_pkg::word_t       prog_word [MAX_ROWS];
  blimp_pkg::inst_trace_t exp_tab   [MAX_ROWS];
  // Architectural register state as the program runs
  blimp_pkg::word_t       shadow    [32];
  int                     num_rows;
  int                     cycles;

  // Checker handshake
  int                     row_idx;
  int                     err_count;
  logic                   done;
  logic                   stalled;
  blimp_pkg::inst_trace_t exp_trace;

  // ----------------------------------------
  // Memory model state
  // ----------------------------------------
  integer                 seed;
  blimp_pkg::opaq_t       pend_tag  [2];
  blimp_pkg::word_t       pend_addr [2];
  int                     pend_wait [2];
  int                     pend_cnt;
  int                     resp_idx;
  logic                   req_fire;
  logic                   resp_fire;
  blimp_pkg::mem_req_t    req_s;
  // Reset as seen before the edge
  logic                   rst_s;

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // RV32 encodings, funct3 000 for add, addi and mul
  function automatic blimp_pkg::word_t i_type(input blimp_pkg::reg_idx_t rd,
                                              input blimp_pkg::reg_idx_t rs1,
                                              input logic [11:0]         imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic blimp_pkg::word_t r_type(input logic [6:0]          f7,
                                              input blimp_pkg::reg_idx_t rd,
                                              input blimp_pkg::reg_idx_t rs1,
                                              input blimp_pkg::reg_idx_t rs2);
    return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  // Row N sits at pc 4*N
  task automatic store_row(input blimp_pkg::word_t    word,
                           input blimp_pkg::reg_idx_t rd,
                           input blimp_pkg::word_t    value,
                           input logic                wen);
    prog_word[num_rows] = word;
    exp_tab[num_rows]   = '{pc: blimp_pkg::word_t'(num_rows * 4), waddr: rd,
                            wdata: value, wen: wen};
    // x0 never changes
    if (wen && (rd != 5'd0)) begin
      shadow[rd] = value;
    end
    num_rows++;
  endtask

  task automatic addi_row(input blimp_pkg::reg_idx_t rd, input blimp_pkg::reg_idx_t rs1,
                          input logic [11:0] imm);
    store_row(i_type(rd, rs1, imm), rd, shadow[rs1] + {{20{imm[11]}}, imm}, 1'b1);
  endtask

  // Sums wrap modulo 2^32
  task automatic add_row(input blimp_pkg::reg_idx_t rd, input blimp_pkg::reg_idx_t rs1,
                         input blimp_pkg::reg_idx_t rs2);
    store_row(r_type(7'b0000000, rd, rs1, rs2), rd, shadow[rs1] + shadow[rs2], 1'b1);
  endtask

  // 32-bit context keeps the low product word
  task automatic mul_row(input blimp_pkg::reg_idx_t rd, input blimp_pkg::reg_idx_t rs1,
                         input blimp_pkg::reg_idx_t rs2);
    store_row(r_type(7'b0000001, rd, rs1, rs2), rd, shadow[rs1] * shadow[rs2], 1'b1);
  endtask

  task automatic bad_row(input blimp_pkg::word_t word);
    store_row(word, word[11:7], '0, 1'b0);
  endtask

  task automatic build_program();
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    // addi chains, both signs
    addi_row(5'd1, 5'd0, 12'd100);
    addi_row(5'd2, 5'd0, 12'hff9);
    addi_row(5'd3, 5'd1, 12'h800);
    addi_row(5'd4, 5'd2, 12'h7ff);
    addi_row(5'd4, 5'd4, 12'd1);
    // Back-to-back dependency, then wrap past 2^32
    add_row(5'd5, 5'd1, 5'd2);
    add_row(5'd6, 5'd5, 5'd5);
    addi_row(5'd7, 5'd0, 12'hfff);
    add_row(5'd8, 5'd7, 5'd1);
    addi_row(5'd9, 5'd0, 12'h7ff);
    // mul small, large, negative
    mul_row(5'd10, 5'd9, 5'd9);
    mul_row(5'd11, 5'd10, 5'd10);
    mul_row(5'd12, 5'd2, 5'd1);
    add_row(5'd13, 5'd12, 5'd11);
    mul_row(5'd14, 5'd2, 5'd2);
    mul_row(5'd15, 5'd11, 5'd7);
    addi_row(5'd16, 5'd15, 12'd3);
    add_row(5'd17, 5'd11, 5'd11);
    // x0 writes, then reads of x0
    addi_row(5'd0, 5'd1, 12'd5);
    add_row(5'd0, 5'd1, 5'd1);
    add_row(5'd18, 5'd0, 5'd1);
    mul_row(5'd19, 5'd0, 5'd6);
    // Unknown words, sub included
    bad_row(32'h0000_0000);
    bad_row(32'hffff_ffff);
    bad_row(r_type(7'b0100000, 5'd20, 5'd1, 5'd2));
    addi_row(5'd20, 5'd18, 12'd1);
    mul_row(5'd21, 5'd20, 5'd13);
    add_row(5'd22, 5'd21, 5'd3);
  endtask

  // Past the table, low bits 01 never decode
  function automatic blimp_pkg::word_t mem_word(input blimp_pkg::word_t addr);
    if ((addr >> 2) < blimp_pkg::word_t'(num_rows)) begin
      return prog_word[addr[7:2]];
    end
    return addr ^ 32'h5a5a_a5a5;
  endfunction

  // ----------------------------------------
  // Memory model, one step per clock
  // ----------------------------------------
  task automatic advance_memory();
    logic ready0;
    logic ready1;
    if (resp_fire) begin
      if ((resp_idx == 0) && (pend_cnt == 2)) begin
        pend_tag[0]  = pend_tag[1];
        pend_addr[0] = pend_addr[1];
        pend_wait[0] = pend_wait[1];
      end
      pend_cnt--;
      mem_resp_val = 1'b0;
    end
    for (int i = 0; i < pend_cnt; i++) begin
      if (pend_wait[i] > 0) begin
        pend_wait[i]--;
      end
    end
    // Delay of 0 to 3 cycles per request
    if (req_fire) begin
      pend_tag[pend_cnt]  = req_s.opaque;
      pend_addr[pend_cnt] = req_s.addr;
      pend_wait[pend_cnt] = $unsigned($random(seed)) % 4;
      pend_cnt++;
    end
    // Payload holds while valid waits for ready
    if (!mem_resp_val && (pend_cnt > 0)) begin
      ready0 = (pend_wait[0] == 0);
      ready1 = (pend_cnt > 1) && (pend_wait[1] == 0);
      resp_idx = -1;
      if (ready0 && ready1) begin
        resp_idx = $random(seed) & 1;
      end else if (ready0) begin
        resp_idx = 0;
      end else if (ready1) begin
        resp_idx = 1;
      end
      if (resp_idx >= 0) begin
        mem_resp_val    = 1'b1;
        mem_resp.opaque = pend_tag[resp_idx];
        mem_resp.data   = mem_word(pend_addr[resp_idx]);
      end
    end
    // Random request back-pressure
    mem_req_rdy = (($random(seed) & 3) != 0);
  endtask

  initial begin
    seed         = 32'hef61;
    mem_req_rdy  = 1'b0;
    mem_resp_val = 1'b0;
    mem_resp     = '0;
    pend_cnt     = 0;
    resp_idx     = 0;
    forever begin
      // Transfers decided on values stable before the edge
      @(negedge clk);
      rst_s     = rst_n;
      req_fire  = rst_n && mem_req_val && mem_req_rdy;
      resp_fire = rst_n && mem_resp_val && mem_resp_rdy;
      req_s     = mem_req;
      @(posedge clk);
      #1;
      if (!rst_s) begin
        pend_cnt     = 0;
        mem_resp_val = 1'b0;
        mem_req_rdy  = 1'b0;
      end else begin
        advance_memory();
      end
    end
  end

  assign exp_trace = (row_idx < num_rows) ? exp_tab[row_idx] : '0;

  blimp_v1 i_blimp_v1 (
    .clk          (clk),
    .rst_n        (rst_n),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_req      (mem_req),
    .mem_resp_val (mem_resp_val),
    .mem_resp_rdy (mem_resp_rdy),
    .mem_resp     (mem_resp),
    .trace_val    (trace_val),
    .trace        (trace)
  );

  blimp_trace_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .mem_req_val  (mem_req_val),
    .mem_req      (mem_req),
    .mem_resp_val (mem_resp_val),
    .mem_resp_rdy (mem_resp_rdy),
    .trace_val    (trace_val),
    .trace        (trace),
    .num_rows     (num_rows),
    .exp_trace    (exp_trace),
    .row_idx      (row_idx),
    .err_count    (err_count),
    .done         (done),
    .stalled      (stalled)
  );

  // ----------------------------------------
  // Reset, run, verdict
  // ----------------------------------------
  initial begin
    rst_n    = 1'b0;
    num_rows = 0;
    build_program();
    repeat (4) @(posedge clk);
    #1;
    rst_n  = 1'b1;
    cycles = 0;
    while (!done && !stalled && (cycles < RUN_LIMIT)) begin
      @(posedge clk);
      cycles++;
    end
    if (!done && !stalled) begin
      $display("Run did not finish within %0d cycles", RUN_LIMIT);
    end
    $display("Rows retired %0d of %0d, errors %0d", row_idx, num_rows, err_count);
    if (done && !stalled && (err_count == 0)) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- src.f
rtl/blimp_pkg.sv
rtl/blimp_fetch.sv
rtl/blimp_regfile.sv
rtl/blimp_decode_issue.sv
rtl/blimp_mul_unit.sv
rtl/blimp_writeback.sv
rtl/blimp_v1.sv
sim/blimp_trace_checker.sv
sim/blimp_v1_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the blimp_v1 testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module blimp_v1_tb \
  -f src.f -Mdir obj_dir -o blimp_v1_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/blimp_v1_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error, see sim.log"
  exit 1
fi

# Verdict comes from the log
if grep -qx "test passed" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
